//--- list.f
source/mem_pkg.sv
source/axi_pkg.sv
source/chan_fifo.sv
source/burst_memory.sv
source/write_engine.sv
source/read_engine.sv
source/axi4_mem_slave.sv
bench/tb_axi4_mem_slave.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_axi4_mem_slave
FILE_LIST ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
PASS_TEXT ?= Verification passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILE_LIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

//--- bench/tb_axi4_mem_slave.sv
module tb_axi4_mem_slave;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int WAIT_LIMIT = 200;
    localparam int UPPER_LSB  = mem_pkg::WORD_INDEX_WIDTH + mem_pkg::LANE_WIDTH;

    logic                            aclk;
    logic                            aresetn;
    logic [axi_pkg::ID_WIDTH-1:0]    awid, bid, arid, rid;
    logic [axi_pkg::ADDR_WIDTH-1:0]  awaddr, araddr;
    logic [axi_pkg::LEN_WIDTH-1:0]   awlen, arlen;
    logic [axi_pkg::SIZE_WIDTH-1:0]  awsize, arsize;
    logic [axi_pkg::DATA_WIDTH-1:0]  wdata, rdata;
    logic [axi_pkg::STRB_WIDTH-1:0]  wstrb;
    logic [axi_pkg::RESP_WIDTH-1:0]  bresp, rresp;
    logic                            awvalid, awready, wlast, wvalid, wready, bvalid, bready;
    logic                            arvalid, arready, rlast, rvalid, rready;

    // reference memory and expected response fields
    logic [31:0]                     ref_mem [mem_pkg::MEM_WORDS];
    logic [axi_pkg::ID_WIDTH-1:0]    exp_bid, exp_rid;
    logic [31:0]                     rd_base, r_addr, exp_rdata;
    logic [7:0]                      exp_len, r_beat;
    int                              b_count, r_bursts, error_mark, tests_passed, tests_failed;
    int                              errors = 0;
    logic                            hung, random_ready;
    logic [15:0]                     lfsr;

    axi4_mem_slave uut (.*);

    function automatic logic next_bit();
        logic bit_out;
        bit_out = lfsr[0];
        lfsr = bit_out ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
        return bit_out;
    endfunction

    function automatic void report_error(input string msg);
        errors++;
        $display("[FAIL] time %0d ns: %s", $time, msg);
    endfunction

    initial begin
        aclk = 1'b0;
        forever #2 aclk = ~aclk;
    end

    // random back-pressure on B and R
    initial begin
        lfsr   = 16'd85;
        bready = 1'b1;
        rready = 1'b1;
        forever begin
            @(negedge aclk);
            if (random_ready) begin
                bready = next_bit();
                rready = next_bit();
            end else begin
                bready = 1'b1;
                rready = 1'b1;
            end
        end
    end

    // ----------------------------------------
    // transfer counters
    // ----------------------------------------
    always @(posedge aclk) begin
        if (!aresetn) begin
            b_count  <= 0;
            r_bursts <= 0;
            r_beat   <= '0;
        end else begin
            if (bvalid && bready) begin
                b_count <= b_count + 1;
            end
            if (rvalid && rready) begin
                if (rlast) begin
                    r_beat   <= '0;
                    r_bursts <= r_bursts + 1;
                end else begin
                    r_beat <= r_beat + 8'd1;
                end
            end
        end
    end

    // word expected on the current beat, zero beyond the memory
    assign r_addr    = rd_base + {22'd0, r_beat, 2'b00};
    assign exp_rdata = (r_addr[31:UPPER_LSB] != '0) ? '0
                     : ref_mem[r_addr[UPPER_LSB-1:mem_pkg::LANE_WIDTH]];

    // ----------------------------------------
    // checks
    // ----------------------------------------
    reset_quiet: assert property (@(posedge aclk) !aresetn |=> !bvalid && !rvalid)
        else report_error("bvalid or rvalid high around reset");

    // queues empty right after reset
    ready_after_reset: assert property (@(posedge aclk)
        $rose(aresetn) |-> awready && wready && arready)
        else report_error("awready, wready or arready low after reset");

    b_payload_ok: assert property (@(posedge aclk) disable iff (!aresetn)
        bvalid && bready |-> bid == exp_bid && bresp == axi_pkg::RESP_OKAY)
        else report_error("bid or bresp wrong");

    b_payload_held: assert property (@(posedge aclk) disable iff (!aresetn)
        bvalid && !bready |=> bvalid && $stable(bid) && $stable(bresp))
        else report_error("B channel changed while stalled");

    r_payload_ok: assert property (@(posedge aclk) disable iff (!aresetn)
        rvalid && rready |-> rid == exp_rid && rresp == axi_pkg::RESP_OKAY
            && rdata == exp_rdata)
        else report_error("rdata, rid or rresp wrong");

    r_last_ok: assert property (@(posedge aclk) disable iff (!aresetn)
        rvalid && rready |-> rlast == (r_beat == exp_len))
        else report_error("rlast on the wrong beat");

    r_payload_held: assert property (@(posedge aclk) disable iff (!aresetn)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rid) && $stable(rlast))
        else report_error("R channel changed while stalled");

    task automatic write_burst(
        input logic [axi_pkg::ID_WIDTH-1:0]   id,
        input logic [axi_pkg::ADDR_WIDTH-1:0] addr,
        input logic [axi_pkg::LEN_WIDTH-1:0]  len,
        input logic [axi_pkg::STRB_WIDTH-1:0] strb,
        input logic [axi_pkg::DATA_WIDTH-1:0] first
    );
        int n;
        int i;
        int k;
        int target;
        logic [31:0] a;
        if (hung) begin
            return;
        end
        target  = b_count + 1;
        exp_bid = id;
        @(negedge aclk);
        awid    = id;
        awaddr  = addr;
        awlen   = len;
        awsize  = axi_pkg::MAX_SIZE;
        awvalid = 1'b1;
        n = 0;
        while (!awready && n < WAIT_LIMIT) begin
            @(negedge aclk);
            n++;
        end
        if (!awready) begin
            hung = 1'b1;
            $display("timeout: awready never rose");
            return;
        end
        a = addr;
        for (i = 0; i <= int'(len); i++) begin
            @(negedge aclk);
            awvalid = 1'b0;
            wdata   = first + 32'(i) * 32'h0101_0101;
            wstrb   = strb;
            wlast   = (i == int'(len));
            wvalid  = 1'b1;
            n = 0;
            while (!wready && n < WAIT_LIMIT) begin
                @(negedge aclk);
                n++;
            end
            if (!wready) begin
                hung = 1'b1;
                $display("timeout: wready never rose");
                return;
            end
            // strobe merge, out of range writes dropped
            if (a[31:UPPER_LSB] == '0) begin
                for (k = 0; k < 4; k++) begin
                    if (strb[k]) begin
                        ref_mem[a[UPPER_LSB-1:2]][k*8 +: 8] = wdata[k*8 +: 8];
                    end
                end
            end
            a = a + 32'd4;
        end
        @(negedge aclk);
        wvalid = 1'b0;
        n = 0;
        while (b_count < target && n < WAIT_LIMIT) begin
            @(negedge aclk);
            n++;
        end
        if (b_count < target) begin
            hung = 1'b1;
            $display("timeout: no write response arrived");
        end
    endtask

    task automatic read_burst(
        input logic [axi_pkg::ID_WIDTH-1:0]   id,
        input logic [axi_pkg::ADDR_WIDTH-1:0] addr,
        input logic [axi_pkg::LEN_WIDTH-1:0]  len
    );
        int n;
        int target;
        if (hung) begin
            return;
        end
        target  = r_bursts + 1;
        exp_rid = id;
        rd_base = addr;
        exp_len = len;
        @(negedge aclk);
        arid    = id;
        araddr  = addr;
        arlen   = len;
        arsize  = axi_pkg::MAX_SIZE;
        arvalid = 1'b1;
        n = 0;
        while (!arready && n < WAIT_LIMIT) begin
            @(negedge aclk);
            n++;
        end
        if (!arready) begin
            hung = 1'b1;
            $display("timeout: arready never rose");
            return;
        end
        @(negedge aclk);
        arvalid = 1'b0;
        n = 0;
        while (r_bursts < target && n < WAIT_LIMIT) begin
            @(negedge aclk);
            n++;
        end
        if (r_bursts < target) begin
            hung = 1'b1;
            $display("timeout: read burst never finished");
        end
    endtask

    task automatic close_test(input string name);
        if (errors == error_mark && !hung) begin
            tests_passed++;
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: errors", name);
        end
        error_mark = errors;
    endtask

    initial begin
        aresetn      = 1'b0;
        awid         = '0;
        awaddr       = '0;
        awlen        = '0;
        awsize       = '0;
        awvalid      = 1'b0;
        wdata        = '0;
        wstrb        = '0;
        wlast        = 1'b0;
        wvalid       = 1'b0;
        arid         = '0;
        araddr       = '0;
        arlen        = '0;
        arsize       = '0;
        arvalid      = 1'b0;
        exp_bid      = '0;
        exp_rid      = '0;
        rd_base      = '0;
        exp_len      = '0;
        hung         = 1'b0;
        random_ready = 1'b0;
        error_mark   = 0;
        tests_passed = 0;
        tests_failed = 0;
        repeat (5) @(posedge aclk);
        @(negedge aclk);
        aresetn = 1'b1;
        repeat (2) @(negedge aclk);
        close_test("1 reset");

        write_burst(4'h3, 32'h0000_0040, 8'd0, 4'hF, 32'hDEAD_BEEF);
        read_burst(4'h5, 32'h0000_0040, 8'd0);
        close_test("2 single beat");

        write_burst(4'h1, 32'h0000_0100, 8'd3, 4'hF, 32'h1020_3040);
        read_burst(4'h2, 32'h0000_0100, 8'd3);
        close_test("3 four beat burst");

        write_burst(4'h4, 32'h0000_0104, 8'd0, 4'b0101, 32'hAABB_CCDD);
        read_burst(4'hA, 32'h0000_0100, 8'd3);
        close_test("4 partial strobe");

        random_ready = 1'b1;
        write_burst(4'h9, 32'h0000_0200, 8'd7, 4'hF, 32'h5A5A_0000);
        read_burst(4'hC, 32'h0000_0200, 8'd7);
        read_burst(4'h1, 32'h0000_0100, 8'd3);
        random_ready = 1'b0;
        close_test("5 back-pressure");

        read_burst(4'h6, 32'h0010_0040, 8'd1);
        write_burst(4'h7, 32'h0010_0100, 8'd0, 4'hF, 32'h1234_5678);
        read_burst(4'h8, 32'h0000_0100, 8'd1);
        close_test("6 out of range");

        $display("tests passed %0d, tests failed %0d, check errors %0d",
                 tests_passed, tests_failed, errors);
        if (errors == 0 && !hung && tests_failed == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- source/axi4_mem_slave.sv
module axi4_mem_slave (
    input  logic                               aclk,
    input  logic                               aresetn,

    input  logic [axi_pkg::ID_WIDTH-1:0]       awid,
    input  logic [axi_pkg::ADDR_WIDTH-1:0]     awaddr,
    input  logic [axi_pkg::LEN_WIDTH-1:0]      awlen,
    input  logic [axi_pkg::SIZE_WIDTH-1:0]     awsize,
    input  logic                               awvalid,
    output logic                               awready,

    input  logic [axi_pkg::DATA_WIDTH-1:0]     wdata,
    input  logic [axi_pkg::STRB_WIDTH-1:0]     wstrb,
    input  logic                               wlast,
    input  logic                               wvalid,
    output logic                               wready,

    output logic [axi_pkg::ID_WIDTH-1:0]       bid,
    output logic [axi_pkg::RESP_WIDTH-1:0]     bresp,
    output logic                               bvalid,
    input  logic                               bready,

    input  logic [axi_pkg::ID_WIDTH-1:0]       arid,
    input  logic [axi_pkg::ADDR_WIDTH-1:0]     araddr,
    input  logic [axi_pkg::LEN_WIDTH-1:0]      arlen,
    input  logic [axi_pkg::SIZE_WIDTH-1:0]     arsize,
    input  logic                               arvalid,
    output logic                               arready,

    output logic [axi_pkg::ID_WIDTH-1:0]       rid,
    output logic [axi_pkg::DATA_WIDTH-1:0]     rdata,
    output logic [axi_pkg::RESP_WIDTH-1:0]     rresp,
    output logic                               rlast,
    output logic                               rvalid,
    input  logic                               rready
);

    // ----------------------------------------
    // queue to engine side
    // ----------------------------------------
    logic [axi_pkg::ID_WIDTH-1:0]         aw_id;
    logic [axi_pkg::ADDR_WIDTH-1:0]       aw_addr;
    logic [axi_pkg::LEN_WIDTH-1:0]        aw_len;
    logic [axi_pkg::SIZE_WIDTH-1:0]       aw_size;
    logic                                 aw_valid;
    logic                                 aw_ready;

    logic [axi_pkg::DATA_WIDTH-1:0]       w_data;
    logic [axi_pkg::STRB_WIDTH-1:0]       w_strb;
    logic                                 w_last;
    logic                                 w_valid;
    logic                                 w_ready;

    logic [axi_pkg::ID_WIDTH-1:0]         ar_id;
    logic [axi_pkg::ADDR_WIDTH-1:0]       ar_addr;
    logic [axi_pkg::LEN_WIDTH-1:0]        ar_len;
    logic [axi_pkg::SIZE_WIDTH-1:0]       ar_size;
    logic                                 ar_valid;
    logic                                 ar_ready;

    // memory ports
    logic                                 wr_en;
    logic [mem_pkg::WORD_INDEX_WIDTH-1:0] wr_index;
    logic [axi_pkg::DATA_WIDTH-1:0]       wr_data;
    logic [axi_pkg::STRB_WIDTH-1:0]       wr_strb;
    logic [mem_pkg::WORD_INDEX_WIDTH-1:0] rd_index;
    logic [axi_pkg::DATA_WIDTH-1:0]       rd_word;

    chan_fifo #(
        .WIDTH(axi_pkg::ID_WIDTH + axi_pkg::ADDR_WIDTH + axi_pkg::LEN_WIDTH + axi_pkg::SIZE_WIDTH),
        .DEPTH(2)
    ) aw_fifo (
        .aclk   (aclk),
        .aresetn(aresetn),
        .s_data ({awid, awaddr, awlen, awsize}),
        .s_valid(awvalid),
        .s_ready(awready),
        .m_data ({aw_id, aw_addr, aw_len, aw_size}),
        .m_valid(aw_valid),
        .m_ready(aw_ready)
    );

    chan_fifo #(
        .WIDTH(axi_pkg::DATA_WIDTH + axi_pkg::STRB_WIDTH + 1),
        .DEPTH(2)
    ) w_fifo (
        .aclk   (aclk),
        .aresetn(aresetn),
        .s_data ({wdata, wstrb, wlast}),
        .s_valid(wvalid),
        .s_ready(wready),
        .m_data ({w_data, w_strb, w_last}),
        .m_valid(w_valid),
        .m_ready(w_ready)
    );

    chan_fifo #(
        .WIDTH(axi_pkg::ID_WIDTH + axi_pkg::ADDR_WIDTH + axi_pkg::LEN_WIDTH + axi_pkg::SIZE_WIDTH),
        .DEPTH(2)
    ) ar_fifo (
        .aclk   (aclk),
        .aresetn(aresetn),
        .s_data ({arid, araddr, arlen, arsize}),
        .s_valid(arvalid),
        .s_ready(arready),
        .m_data ({ar_id, ar_addr, ar_len, ar_size}),
        .m_valid(ar_valid),
        .m_ready(ar_ready)
    );

    // ----------------------------------------
    // engines and storage
    // ----------------------------------------
    write_engine u_write_engine (
        .aclk    (aclk),
        .aresetn (aresetn),
        .aw_id   (aw_id),
        .aw_addr (aw_addr),
        .aw_len  (aw_len),
        .aw_size (aw_size),
        .aw_valid(aw_valid),
        .aw_ready(aw_ready),
        .w_data  (w_data),
        .w_strb  (w_strb),
        .w_last  (w_last),
        .w_valid (w_valid),
        .w_ready (w_ready),
        .wr_en   (wr_en),
        .wr_index(wr_index),
        .wr_data (wr_data),
        .wr_strb (wr_strb),
        .bid     (bid),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready)
    );

    read_engine u_read_engine (
        .aclk    (aclk),
        .aresetn (aresetn),
        .ar_id   (ar_id),
        .ar_addr (ar_addr),
        .ar_len  (ar_len),
        .ar_size (ar_size),
        .ar_valid(ar_valid),
        .ar_ready(ar_ready),
        .rd_index(rd_index),
        .rd_word (rd_word),
        .rid     (rid),
        .rdata   (rdata),
        .rresp   (rresp),
        .rlast   (rlast),
        .rvalid  (rvalid),
        .rready  (rready)
    );

    burst_memory u_burst_memory (
        .aclk    (aclk),
        .wr_en   (wr_en),
        .wr_index(wr_index),
        .wr_data (wr_data),
        .wr_strb (wr_strb),
        .rd_index(rd_index),
        .rd_word (rd_word)
    );

endmodule

//--- source/read_engine.sv
module read_engine (
    input  logic                                 aclk,
    input  logic                                 aresetn,
    input  logic [axi_pkg::ID_WIDTH-1:0]         ar_id,
    input  logic [axi_pkg::ADDR_WIDTH-1:0]       ar_addr,
    input  logic [axi_pkg::LEN_WIDTH-1:0]        ar_len,
    input  logic [axi_pkg::SIZE_WIDTH-1:0]       ar_size,
    input  logic                                 ar_valid,
    output logic                                 ar_ready,
    output logic [mem_pkg::WORD_INDEX_WIDTH-1:0] rd_index,
    input  logic [axi_pkg::DATA_WIDTH-1:0]       rd_word,
    output logic [axi_pkg::ID_WIDTH-1:0]         rid,
    output logic [axi_pkg::DATA_WIDTH-1:0]       rdata,
    output logic [axi_pkg::RESP_WIDTH-1:0]       rresp,
    output logic                                 rlast,
    output logic                                 rvalid,
    input  logic                                 rready
);

    axi_pkg::axi_addr_u               burst_addr;
    logic [axi_pkg::LEN_WIDTH-1:0]    beats_left;
    logic [axi_pkg::SIZE_WIDTH-1:0]   burst_size;

    axi_pkg::axi_addr_u               load_addr;
    logic [axi_pkg::ADDR_WIDTH-1:0]   step;
    logic                             ar_take;
    logic                             r_take;
    logic                             load;

    assign r_take   = rvalid && rready;
    assign ar_ready = !rvalid || (r_take && rlast);
    assign ar_take  = ar_valid && ar_ready;

    // ----------------------------------------
    // address for the beat about to be shown
    // ----------------------------------------
    assign step      = 1 << burst_size;
    assign load_addr = ar_take ? ar_addr : burst_addr.addr + step;
    assign load      = ar_take || (r_take && !rlast);
    assign rd_index  = load_addr.fields.index;

    assign rlast = (beats_left == '0);
    assign rresp = axi_pkg::RESP_OKAY;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            rvalid <= 1'b0;
        end else if (ar_take) begin
            rvalid <= 1'b1;
        end else if (r_take && rlast) begin
            rvalid <= 1'b0;
        end
    end

    // beat payload, held under back-pressure
    always_ff @(posedge aclk) begin
        if (ar_take) begin
            rid        <= ar_id;
            burst_size <= ar_size;
            beats_left <= ar_len;
        end else if (r_take) begin
            beats_left <= beats_left - 1'b1;
        end
        if (load) begin
            burst_addr <= load_addr;
            // out of range reads as zero
            rdata <= (load_addr.fields.upper == '0) ? rd_word : '0;
        end
    end

    r_payload_stable: assert property (
        @(posedge aclk) disable iff (!aresetn)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rlast) && $stable(rid)
    );

endmodule

//--- source/write_engine.sv
module write_engine (
    input  logic                                 aclk,
    input  logic                                 aresetn,
    input  logic [axi_pkg::ID_WIDTH-1:0]         aw_id,
    input  logic [axi_pkg::ADDR_WIDTH-1:0]       aw_addr,
    input  logic [axi_pkg::LEN_WIDTH-1:0]        aw_len,
    input  logic [axi_pkg::SIZE_WIDTH-1:0]       aw_size,
    input  logic                                 aw_valid,
    output logic                                 aw_ready,
    input  logic [axi_pkg::DATA_WIDTH-1:0]       w_data,
    input  logic [axi_pkg::STRB_WIDTH-1:0]       w_strb,
    input  logic                                 w_last,
    input  logic                                 w_valid,
    output logic                                 w_ready,
    output logic                                 wr_en,
    output logic [mem_pkg::WORD_INDEX_WIDTH-1:0] wr_index,
    output logic [axi_pkg::DATA_WIDTH-1:0]       wr_data,
    output logic [axi_pkg::STRB_WIDTH-1:0]       wr_strb,
    output logic [axi_pkg::ID_WIDTH-1:0]         bid,
    output logic [axi_pkg::RESP_WIDTH-1:0]       bresp,
    output logic                                 bvalid,
    input  logic                                 bready
);

    logic                             busy;
    axi_pkg::axi_addr_u               burst_addr;
    logic [axi_pkg::LEN_WIDTH-1:0]    beats_left;
    logic [axi_pkg::SIZE_WIDTH-1:0]   burst_size;

    axi_pkg::axi_addr_u               cur_addr;
    logic [axi_pkg::LEN_WIDTH-1:0]    cur_len;
    logic [axi_pkg::SIZE_WIDTH-1:0]   cur_size;
    logic [axi_pkg::ADDR_WIDTH-1:0]   step;
    logic                             b_stall;
    logic                             aw_take;
    logic                             w_take;
    logic                             last_beat;

    // ----------------------------------------
    // handshakes
    // ----------------------------------------
    assign b_stall  = bvalid && !bready;
    assign aw_ready = aw_valid && !busy && !b_stall;
    assign w_ready  = (busy || aw_valid) && !b_stall;
    assign aw_take  = aw_valid && aw_ready;
    assign w_take   = w_valid && w_ready;

    // first beat may arrive with its address
    assign cur_addr  = busy ? burst_addr : aw_addr;
    assign cur_len   = busy ? beats_left : aw_len;
    assign cur_size  = busy ? burst_size : aw_size;
    assign step      = 1 << cur_size;
    assign last_beat = (cur_len == '0);

    // ----------------------------------------
    // memory write port
    // ----------------------------------------
    assign wr_en    = w_take && (cur_addr.fields.upper == '0);
    assign wr_index = cur_addr.fields.index;
    assign wr_data  = w_data;
    assign wr_strb  = w_strb;

    assign bresp = axi_pkg::RESP_OKAY;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            busy   <= 1'b0;
            bvalid <= 1'b0;
        end else begin
            if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
            if (aw_take) begin
                busy <= 1'b1;
            end
            if (w_take && last_beat) begin
                busy   <= 1'b0;
                bvalid <= 1'b1;
            end
        end
    end

    // burst state
    always_ff @(posedge aclk) begin
        if (aw_take) begin
            bid        <= aw_id;
            burst_size <= aw_size;
        end
        if (w_take) begin
            burst_addr <= cur_addr.addr + step;
            beats_left <= cur_len - 1'b1;
        end else if (aw_take) begin
            burst_addr <= cur_addr;
            beats_left <= cur_len;
        end
    end

    wlast_matches_len: assert property (
        @(posedge aclk) disable iff (!aresetn) w_take |-> (w_last == last_beat)
    );

    aw_size_legal: assert property (
        @(posedge aclk) disable iff (!aresetn) aw_valid |-> (aw_size <= axi_pkg::MAX_SIZE)
    );

    // response held until the master takes it
    bvalid_held: assert property (
        @(posedge aclk) disable iff (!aresetn) b_stall |=> bvalid && $stable(bid)
    );

endmodule

//--- source/burst_memory.sv
module burst_memory (
    input  logic                                 aclk,
    input  logic                                 wr_en,
    input  logic [mem_pkg::WORD_INDEX_WIDTH-1:0] wr_index,
    input  logic [axi_pkg::DATA_WIDTH-1:0]       wr_data,
    input  logic [axi_pkg::STRB_WIDTH-1:0]       wr_strb,
    input  logic [mem_pkg::WORD_INDEX_WIDTH-1:0] rd_index,
    output logic [axi_pkg::DATA_WIDTH-1:0]       rd_word
);

    logic [axi_pkg::DATA_WIDTH-1:0] mem [mem_pkg::MEM_WORDS];

    // only strobed bytes change
    always_ff @(posedge aclk) begin
        if (wr_en) begin
            for (int lane = 0; lane < axi_pkg::STRB_WIDTH; lane++) begin
                if (wr_strb[lane]) begin
                    mem[wr_index][lane*8 +: 8] <= wr_data[lane*8 +: 8];
                end
            end
        end
    end

    // asynchronous read
    assign rd_word = mem[rd_index];

endmodule

//--- source/chan_fifo.sv
module chan_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 2
) (
    input  logic             aclk,
    input  logic             aresetn,
    input  logic [WIDTH-1:0] s_data,
    input  logic             s_valid,
    output logic             s_ready,
    output logic [WIDTH-1:0] m_data,
    output logic             m_valid,
    input  logic             m_ready
);

    localparam int PTR_WIDTH = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_WIDTH = $clog2(DEPTH + 1);

    logic [WIDTH-1:0]     slots [DEPTH];
    logic [PTR_WIDTH-1:0] wr_ptr;
    logic [PTR_WIDTH-1:0] rd_ptr;
    logic [CNT_WIDTH-1:0] count;
    logic                 push;
    logic                 pop;

    // circular wrap for any depth
    function automatic logic [PTR_WIDTH-1:0] next_ptr(input logic [PTR_WIDTH-1:0] ptr);
        return (ptr == PTR_WIDTH'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign s_ready = (count != CNT_WIDTH'(DEPTH));
    assign m_valid = (count != '0);
    assign m_data  = slots[rd_ptr];
    assign push    = s_valid && s_ready;
    assign pop     = m_valid && m_ready;

    always_ff @(posedge aclk) begin
        if (!aresetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // storage
    always_ff @(posedge aclk) begin
        if (push) begin
            slots[wr_ptr] <= s_data;
        end
    end

    count_in_range: assert property (
        @(posedge aclk) disable iff (!aresetn) count <= CNT_WIDTH'(DEPTH)
    );

endmodule

//--- source/axi_pkg.sv
package axi_pkg;

    // ----------------------------------------
    // channel field widths
    // ----------------------------------------
    localparam int ID_WIDTH   = 4;
    localparam int ADDR_WIDTH = 32;
    localparam int DATA_WIDTH = 32;
    localparam int STRB_WIDTH = DATA_WIDTH / 8;
    localparam int LEN_WIDTH  = 8;
    localparam int SIZE_WIDTH = 3;

    // 4 bytes per beat at most
    localparam logic [SIZE_WIDTH-1:0] MAX_SIZE = 3'd2;

    // ----------------------------------------
    // responses
    // ----------------------------------------
    localparam int RESP_WIDTH = 2;
    localparam logic [RESP_WIDTH-1:0] RESP_OKAY = 2'b00;

    // ----------------------------------------
    // byte address, stepped as a whole or split for the memory
    // ----------------------------------------
    typedef union packed {
        logic [ADDR_WIDTH-1:0] addr;
        struct packed {
            // non-zero means outside the memory
            logic [mem_pkg::UPPER_WIDTH-1:0]      upper;
            logic [mem_pkg::WORD_INDEX_WIDTH-1:0] index;
            logic [mem_pkg::LANE_WIDTH-1:0]       lane;
        } fields;
    } axi_addr_u;

endpackage

//--- source/mem_pkg.sv
package mem_pkg;

    // word memory geometry
    localparam int WORD_INDEX_WIDTH = 10;
    localparam int MEM_WORDS        = 1 << WORD_INDEX_WIDTH;

    // byte lane inside a 32-bit word
    localparam int LANE_WIDTH = 2;

    // rest of a 32-bit byte address above index and lane
    localparam int UPPER_WIDTH = 32 - WORD_INDEX_WIDTH - LANE_WIDTH;

endpackage
